// File: all.f
+incdir+include
+incdir+test
hw/adc_pack.sv
hw/capture_pack.sv
hw/sram.sv
hw/oneshot_memory.sv
hw/capture_trigger.sv
hw/readout_port.sv
hw/capture_top.sv
test/capture_tb.sv

// File: test/capture_tb_tasks.svh
`ifndef CAPTURE_TB_TASKS_SVH
`define CAPTURE_TB_TASKS_SVH

//////////////////////////////////////////////////
// compare tasks.

task automatic check_sample(input string name, input adc_sample_t exp, input adc_sample_t act);
    if (act !== exp) begin
        $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        n_mismatch++;
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
        n_mismatch++;
    end
endtask

task automatic check_addr(input string name, input capture_pack::sys_addr_t exp,
                          input capture_pack::sys_addr_t act);
    if (act !== exp) begin
        $display("mismatch at %0t: %s expected %0h, got %0h", $time, name, exp, act);
        n_mismatch++;
    end
endtask

//////////////////////////////////////////////////
// stimulus.

task automatic drive_adc_word();
    adc_word_t w;
    for (int i = 0; i < `N_MEM_WIDTH; i++) begin
        w[i] = adc_sample_t'($random(seed));
        if (quiet_cycles > 0) begin
            w[i] = w[i] >>> 2;
        end
    end
    if (quiet_cycles > 0) begin
        quiet_cycles--;
    end
    adc_in = w;
    word_log[edge_cnt + 1] = w;
endtask

task automatic arm_capture(input trig_mode_t mode, input adc_sample_t level);
    @(negedge clk);
    arm          = 1'b1;
    trig_mode    = mode;
    trig_level   = level;
    cur_arm_edge = edge_cnt + 1;
    cur_mode     = mode;
    cur_level    = level;
    @(negedge clk);
    arm = 1'b0;
    check_flag("busy", 1'b1, busy);
endtask

task automatic wait_done();
    int n;
    n = 0;
    do begin
        @(negedge clk);
        n++;
        if (done !== 1'b1) begin
            check_flag("busy", 1'b1, busy);
        end
    end while (done !== 1'b1 && n < wait_limit);
    if (done !== 1'b1) begin
        $display("error at %0t: timed out waiting for done", $time);
        n_fail++;
    end else begin
        check_flag("busy", 1'b0, busy);
        @(negedge clk);
        check_flag("done", 1'b0, done);
    end
endtask

task automatic drain_reads();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < wait_limit) begin
        @(negedge clk);
        n++;
    end
    if (exp_q.size() != 0) begin
        $display("error at %0t: %0d reads never returned", $time, exp_q.size());
        n_fail++;
        exp_q.delete();
    end
    @(negedge clk);
endtask

// read k answers right after edge R+2 of its strobe.
task automatic check_read_timing(input int first_edge, input int count);
    if (valid_edges.size() != count) begin
        $display("error: %0d reads issued, %0d answers seen", count, valid_edges.size());
        n_fail++;
    end else begin
        for (int i = 0; i < count; i++) begin
            if (valid_edges[i] != first_edge + 2 + i) begin
                $display("error: read %0d answered after edge %0d instead of edge %0d",
                         i, valid_edges[i], first_edge + 2 + i);
                n_fail++;
            end
        end
    end
endtask

task automatic read_sample(input sys_addr_t word, input lane_t lane);
    int r;
    valid_edges.delete();
    @(negedge clk);
    rd_strobe    = 1'b1;
    rd_addr.word = word;
    rd_addr.lane = lane;
    last_rd_word = word;
    r            = edge_cnt + 1;
    exp_q.push_back(exp_buf[word][lane]);
    @(negedge clk);
    rd_strobe = 1'b0;
    check_addr("mem_addr", word, i_dut.mem_addr);
    drain_reads();
    check_read_timing(r, 1);
endtask

task automatic read_burst(input sys_addr_t first, input int count);
    int        r;
    lane_t     lane;
    sys_addr_t word;
    valid_edges.delete();
    for (int i = 0; i < count; i++) begin
        @(negedge clk);
        word         = sys_addr_t'(first + i);
        lane         = lane_t'($random(seed));
        rd_strobe    = 1'b1;
        rd_addr.word = word;
        rd_addr.lane = lane;
        last_rd_word = word;
        exp_q.push_back(exp_buf[word][lane]);
        if (i == 0) begin
            r = edge_cnt + 1;
        end
    end
    @(negedge clk);
    rd_strobe = 1'b0;
    drain_reads();
    check_read_timing(r, count);
endtask

//////////////////////////////////////////////////
// reference model.

// trigger edge from the mode rule, then word k from edge T+2+k.
task automatic build_expected(input int arm_edge, input trig_mode_t mode,
                              input adc_sample_t level);
    int   t;
    logic hit;
    t   = arm_edge + 1;
    hit = (mode == TRIG_IMMEDIATE);
    while (!hit && t < edge_cnt) begin
        for (int i = 0; i < `N_MEM_WIDTH; i++) begin
            if (word_log[t][i] >= level) begin
                hit = 1'b1;
            end
        end
        if (!hit) begin
            t++;
        end
    end
    for (int k = 0; k < n_words; k++) begin
        exp_buf[k] = word_log[t + 2 + k];
    end
endtask

`endif

// File: test/capture_tb.sv
`include "capture_params.svh"

module capture_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import adc_pack::*;
    import capture_pack::*;

    localparam int n_words    = `N_MEM_TILES * (1 << `N_MEM_ADDR);
    localparam int wait_limit = 2000;

    logic        clk;
    logic        rstb;
    adc_word_t   adc_in;
    logic        arm;
    trig_mode_t  trig_mode;
    adc_sample_t trig_level;
    logic        busy;
    logic        done;
    logic        rd_strobe;
    rd_addr_t    rd_addr;
    logic        rd_valid;
    adc_sample_t rd_data;

    int          seed = 32'h5469_a73a;
    int          edge_cnt;
    int          quiet_cycles;
    int          n_mismatch;
    int          n_fail;
    int          done_count;
    logic        skip_data;

    // every driven word, keyed by the edge that samples it.
    adc_word_t   word_log [int];
    adc_word_t   exp_buf [n_words];
    adc_sample_t exp_q [$];
    int          valid_edges [$];

    int          cur_arm_edge;
    trig_mode_t  cur_mode;
    adc_sample_t cur_level;
    sys_addr_t   last_rd_word;

    capture_top i_dut (
        .clk       (clk),
        .rstb      (rstb),
        .adc_in    (adc_in),
        .arm       (arm),
        .trig_mode (trig_mode),
        .trig_level(trig_level),
        .busy      (busy),
        .done      (done),
        .rd_strobe (rd_strobe),
        .rd_addr   (rd_addr),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data)
    );

    `include "capture_tb_tasks.svh"

    //////////////////////////////////////////////////
    // clock, edge count and adc source.

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    always @(negedge clk) begin
        drive_adc_word();
    end

    // read answers come back in request order.
    always @(negedge clk) begin
        adc_sample_t exp_s;
        if (rstb && done === 1'b1) begin
            done_count++;
        end
        if (rstb && rd_valid === 1'b1) begin
            valid_edges.push_back(edge_cnt);
            if (exp_q.size() == 0) begin
                $display("error at %0t: rd_valid with no read outstanding", $time);
                n_fail++;
            end else begin
                exp_s = exp_q.pop_front();
                if (!skip_data) begin
                    check_sample("rd_data", exp_s, rd_data);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // directed tests.

    task automatic after_reset_idle();
        check_flag("busy", 1'b0, busy);
        check_flag("done", 1'b0, done);
        check_flag("rd_valid", 1'b0, rd_valid);
        // memory holds nothing yet, only timing counts.
        skip_data = 1'b1;
        read_sample(sys_addr_t'(8'h05), lane_t'(2));
        skip_data = 1'b0;
    endtask

    task automatic immediate_capture();
        done_count = 0;
        arm_capture(TRIG_IMMEDIATE, '0);
        wait_done();
        repeat (4) @(negedge clk);
        if (done_count != 1) begin
            $display("error: done pulsed %0d times for one capture", done_count);
            n_fail++;
        end
        build_expected(cur_arm_edge, cur_mode, cur_level);
        for (int k = 0; k < n_words; k++) begin
            read_sample(sys_addr_t'(k), lane_t'($random(seed)));
        end
    endtask

    task automatic level_capture();
        // small samples for a few cycles keep the level out of reach.
        quiet_cycles = 8;
        arm_capture(TRIG_LEVEL, 8'sd64);
        wait_done();
        build_expected(cur_arm_edge, cur_mode, cur_level);
        read_burst('0, n_words);
    endtask

    task automatic back_to_back_reads();
        read_burst(sys_addr_t'(8'h38), 16);
        read_burst(sys_addr_t'(n_words - 4), 4);
    endtask

    task automatic requests_while_busy();
        arm_capture(TRIG_IMMEDIATE, '0);
        repeat (20) @(negedge clk);
        rd_strobe    = 1'b1;
        rd_addr.word = sys_addr_t'(8'h12);
        rd_addr.lane = lane_t'(3);
        arm          = 1'b1;
        trig_mode    = TRIG_LEVEL;
        trig_level   = 8'sd127;
        @(negedge clk);
        arm = 1'b0;
        repeat (3) @(negedge clk);
        rd_strobe = 1'b0;
        // the read address stays at the last request taken before the capture.
        check_addr("mem_addr", last_rd_word, i_dut.mem_addr);
        wait_done();
        build_expected(cur_arm_edge, cur_mode, cur_level);
        read_burst('0, n_words);
    endtask

    task automatic second_capture();
        // lowest signed level fires on the first armed edge.
        arm_capture(TRIG_LEVEL, -8'sd128);
        wait_done();
        build_expected(cur_arm_edge, cur_mode, cur_level);
        read_burst('0, n_words);
    endtask

    initial begin
        rstb         = 1'b0;
        arm          = 1'b0;
        trig_mode    = TRIG_IMMEDIATE;
        trig_level   = '0;
        rd_strobe    = 1'b0;
        rd_addr      = '0;
        edge_cnt     = 0;
        quiet_cycles = 0;
        n_mismatch   = 0;
        n_fail       = 0;
        done_count   = 0;
        skip_data    = 1'b0;
        foreach (adc_in[i]) begin
            adc_in[i] = '0;
        end
        repeat (4) @(negedge clk);
        rstb = 1'b1;
        after_reset_idle();
        immediate_capture();
        level_capture();
        back_to_back_reads();
        requests_while_busy();
        second_capture();
        $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_fail);
        if (n_mismatch == 0 && n_fail == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: hw/capture_top.sv
module capture_top (
    input  logic                     clk,
    input  logic                     rstb,
    input  adc_pack::adc_word_t      adc_in,
    input  logic                     arm,
    input  capture_pack::trig_mode_t trig_mode,
    input  adc_pack::adc_sample_t    trig_level,
    output logic                     busy,
    output logic                     done,
    input  logic                     rd_strobe,
    input  capture_pack::rd_addr_t   rd_addr,
    output logic                     rd_valid,
    output adc_pack::adc_sample_t    rd_data
);

    import adc_pack::*;
    import capture_pack::*;

    logic      start_write;
    logic      capture_done;
    sys_addr_t mem_addr;
    adc_word_t mem_data;

    capture_trigger u_trigger (
        .clk         (clk),
        .rstb        (rstb),
        .arm         (arm),
        .trig_mode   (trig_mode),
        .trig_level  (trig_level),
        .adc_in      (adc_in),
        .capture_done(capture_done),
        .start_write (start_write),
        .busy        (busy),
        .done        (done)
    );

    // write address is internal to the memory here.
    oneshot_memory u_memory (
        .clk           (clk),
        .rstb          (rstb),
        .in_bytes      (adc_in),
        .in_start_write(start_write),
        .in_addr       (mem_addr),
        .out_data      (mem_data),
        .addr          (),
        .capture_done  (capture_done)
    );

    readout_port u_readout (
        .clk      (clk),
        .rstb     (rstb),
        .rd_strobe(rd_strobe),
        .rd_addr  (rd_addr),
        .busy     (busy),
        .out_data (mem_data),
        .mem_addr (mem_addr),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

endmodule

// File: hw/readout_port.sv
module readout_port (
    input  logic                    clk,
    input  logic                    rstb,
    input  logic                    rd_strobe,
    input  capture_pack::rd_addr_t  rd_addr,
    input  logic                    busy,
    input  adc_pack::adc_word_t     out_data,
    output capture_pack::sys_addr_t mem_addr,
    output logic                    rd_valid,
    output adc_pack::adc_sample_t   rd_data
);

    import capture_pack::*;

    logic  accept;
    lane_t lane_q1;
    lane_t lane_q2;
    logic  valid_q1;
    logic  valid_q2;

    // requests during a capture are dropped.
    assign accept = rd_strobe && !busy;

    always_ff @(posedge clk) begin
        if (!rstb) begin
            mem_addr <= '0;
            valid_q1 <= 1'b0;
            valid_q2 <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            if (accept) begin
                mem_addr <= rd_addr.word;
            end
            valid_q1 <= accept;
            valid_q2 <= valid_q1;
            rd_valid <= valid_q2;
        end
    end

    //////////////////////////////////////////////////
    // lane index follows the sram read by two stages.

    always_ff @(posedge clk) begin
        lane_q1 <= rd_addr.lane;
        lane_q2 <= lane_q1;
        if (valid_q2) begin
            rd_data <= out_data[lane_q2];
        end
    end

    // the sram address stays put for the whole capture.
    a_addr_hold: assert property (@(posedge clk) disable iff (!rstb)
        busy |=> $stable(mem_addr));

endmodule

// File: hw/capture_trigger.sv
module capture_trigger (
    input  logic                     clk,
    input  logic                     rstb,
    input  logic                     arm,
    input  capture_pack::trig_mode_t trig_mode,
    input  adc_pack::adc_sample_t    trig_level,
    input  adc_pack::adc_word_t      adc_in,
    input  logic                     capture_done,
    output logic                     start_write,
    output logic                     busy,
    output logic                     done
);

    import adc_pack::*;
    import capture_pack::*;

    typedef enum logic [1:0] {
        IDLE,
        ARMED,
        CAPTURE,
        FINISH
    } trig_state_t;

    trig_state_t state;
    trig_mode_t  mode_q;
    adc_sample_t level_q;
    logic        level_hit;
    logic        fire;

    // mode and level only load when a new capture is accepted.
    always_ff @(posedge clk) begin
        if (arm && state == IDLE) begin
            mode_q  <= trig_mode;
            level_q <= trig_level;
        end
    end

    // any lane at or above the level, signed.
    always_comb begin
        level_hit = 1'b0;
        for (int i = 0; i < $size(adc_in); i++) begin
            if (adc_in[i] >= level_q) begin
                level_hit = 1'b1;
            end
        end
    end

    assign fire = (mode_q == TRIG_IMMEDIATE) || level_hit;

    //////////////////////////////////////////////////
    // arm, fire, and hand back.

    always_ff @(posedge clk) begin
        if (!rstb) begin
            state       <= IDLE;
            start_write <= 1'b0;
            busy        <= 1'b0;
            done        <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (arm) begin
                        busy  <= 1'b1;
                        state <= ARMED;
                    end
                end
                ARMED: begin
                    if (fire) begin
                        start_write <= 1'b1;
                        state       <= CAPTURE;
                    end
                end
                CAPTURE: begin
                    if (capture_done) begin
                        start_write <= 1'b0;
                        state       <= FINISH;
                    end
                end
                FINISH: begin
                    // memory is idle again once capture_done falls.
                    if (!capture_done) begin
                        busy  <= 1'b0;
                        done  <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: begin
                    start_write <= 1'b0;
                    busy        <= 1'b0;
                    state       <= IDLE;
                end
            endcase
        end
    end

    a_done_single: assert property (@(posedge clk) disable iff (!rstb)
        done |=> !done);

endmodule

// File: hw/oneshot_memory.sv
`include "capture_params.svh"

module oneshot_memory #(
    parameter int n_mem_tiles = `N_MEM_TILES
) (
    input  logic                    clk,
    input  logic                    rstb,
    input  adc_pack::adc_word_t     in_bytes,
    input  logic                    in_start_write,
    input  capture_pack::sys_addr_t in_addr,
    output adc_pack::adc_word_t     out_data,
    output capture_pack::sys_addr_t addr,
    output logic                    capture_done
);

    import adc_pack::*;
    import capture_pack::*;

    ctrl_state_t ctrl_state;
    logic        web;
    sys_addr_t   write_addr;

    sys_addr_t   cur_addr;
    tile_t       tile_idx;
    tile_addr_t  tile_addr;
    tile_t       rd_tile;

    logic [n_mem_tiles-1:0] tile_ceb;

    mem_word_t   wr_word;
    mem_word_t   tile_q [n_mem_tiles];

    //////////////////////////////////////////////////
    // write control.

    // one pass over the whole buffer, then wait for start to drop.
    always_ff @(posedge clk) begin
        if (!rstb) begin
            ctrl_state <= WAIT_FOR_WRITE;
            web        <= 1'b1;
            write_addr <= '0;
        end else begin
            case (ctrl_state)
                WAIT_FOR_WRITE: begin
                    write_addr <= '0;
                    if (in_start_write) begin
                        web        <= 1'b0;
                        ctrl_state <= WRITE_IN_PROGRESS;
                    end
                end
                WRITE_IN_PROGRESS: begin
                    if (write_addr == SYS_ADDR_MAX) begin
                        web        <= 1'b1;
                        ctrl_state <= WRITE_DONE;
                    end else begin
                        write_addr <= write_addr + 1'b1;
                    end
                end
                WRITE_DONE: begin
                    if (!in_start_write) begin
                        ctrl_state <= WAIT_FOR_WRITE;
                    end
                end
                default: begin
                    web        <= 1'b1;
                    write_addr <= '0;
                    ctrl_state <= WAIT_FOR_WRITE;
                end
            endcase
        end
    end

    assign addr         = write_addr;
    assign capture_done = (ctrl_state == WRITE_DONE);

    //////////////////////////////////////////////////
    // tile address and select decode.

    // host address owns the array whenever no write is pending.
    assign cur_addr  = web ? in_addr : write_addr;
    assign tile_idx  = cur_addr[SYS_ADDR_BITS-1:`N_MEM_ADDR];
    assign tile_addr = cur_addr[`N_MEM_ADDR-1:0];

    // remember which tile produced q on the last read.
    always_ff @(posedge clk) begin
        if (web) begin
            rd_tile <= tile_idx;
        end
    end

    //////////////////////////////////////////////////
    // sram tiles.

    assign wr_word = pack_word(in_bytes);

    for (genvar g = 0; g < n_mem_tiles; g++) begin : g_tile
        assign tile_ceb[g] = (tile_idx != tile_t'(g));

        sram #(
            .adr_bits(`N_MEM_ADDR),
            .dat_bits($bits(mem_word_t))
        ) u_sram (
            .clk(clk),
            .ceb(tile_ceb[g]),
            .web(tile_ceb[g] | web),
            .a  (tile_addr),
            .d  (wr_word),
            .q  (tile_q[g])
        );
    end

    assign out_data = unpack_word(tile_q[rd_tile]);

    // writes only happen while the trigger still holds start.
    a_web_in_write: assert property (@(posedge clk) disable iff (!rstb)
        !web |-> (ctrl_state == WRITE_IN_PROGRESS) && in_start_write);

    // write address only climbs until the fsm is back to idle.
    a_addr_mono: assert property (@(posedge clk) disable iff (!rstb)
        (ctrl_state != WAIT_FOR_WRITE) |=> (addr >= $past(addr)));

endmodule

// File: hw/sram.sv
`include "capture_params.svh"

module sram #(
    parameter int adr_bits = `N_MEM_ADDR,
    parameter int dat_bits = `N_MEM_WIDTH * `N_ADC
) (
    input  logic                clk,
    input  logic                ceb,
    input  logic                web,
    input  logic [adr_bits-1:0] a,
    input  logic [dat_bits-1:0] d,
    output logic [dat_bits-1:0] q
);

    //////////////////////////////////////////////////
    // behavioral stand-in for the single-port macro.

    logic [dat_bits-1:0] mem [2**adr_bits];

    // q only moves on a read cycle.
    always_ff @(posedge clk) begin
        if (!ceb) begin
            if (!web) begin
                mem[a] <= d;
            end else begin
                q <= mem[a];
            end
        end
    end

endmodule

// File: hw/capture_pack.sv
`include "capture_params.svh"

package capture_pack;

    localparam int TILE_BITS     = $clog2(`N_MEM_TILES);
    localparam int SYS_ADDR_BITS = TILE_BITS + `N_MEM_ADDR;

    typedef logic [TILE_BITS-1:0]   tile_t;
    typedef logic [`N_MEM_ADDR-1:0] tile_addr_t;

    // tile index sits above the address inside the tile.
    typedef logic [SYS_ADDR_BITS-1:0] sys_addr_t;

    typedef logic [$clog2(`N_MEM_WIDTH)-1:0] lane_t;

    typedef struct packed {
        sys_addr_t word;
        lane_t     lane;
    } rd_addr_t;

    localparam sys_addr_t SYS_ADDR_MAX = '1;

    typedef enum logic [1:0] {
        WAIT_FOR_WRITE,
        WRITE_IN_PROGRESS,
        WRITE_DONE
    } ctrl_state_t;

    typedef enum logic {
        TRIG_IMMEDIATE,
        TRIG_LEVEL
    } trig_mode_t;

endpackage

// File: hw/adc_pack.sv
`include "capture_params.svh"

package adc_pack;

    typedef logic signed [`N_ADC-1:0] adc_sample_t;

    // one adc cycle of samples, lane 0 first.
    typedef adc_sample_t adc_word_t [`N_MEM_WIDTH];

    // flat sram word, lane 0 in the low bits.
    typedef logic [`N_MEM_WIDTH*`N_ADC-1:0] mem_word_t;

    function automatic mem_word_t pack_word(input adc_word_t w);
        mem_word_t m;
        for (int i = 0; i < `N_MEM_WIDTH; i++) begin
            m[i*`N_ADC +: `N_ADC] = w[i];
        end
        return m;
    endfunction

    function automatic adc_word_t unpack_word(input mem_word_t m);
        adc_word_t w;
        for (int i = 0; i < `N_MEM_WIDTH; i++) begin
            w[i] = adc_sample_t'(m[i*`N_ADC +: `N_ADC]);
        end
        return w;
    endfunction

endpackage

// File: include/capture_params.svh
`ifndef CAPTURE_PARAMS_SVH
`define CAPTURE_PARAMS_SVH

// bits per adc sample.
`define N_ADC 8

// samples per memory word, one adc cycle.
`define N_MEM_WIDTH 16

// address bits inside one tile.
`define N_MEM_ADDR 6

// number of sram tiles.
`define N_MEM_TILES 4

`endif
